// File: Bender.yml
package:
  name: conv_layer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/conv_pkg.sv
      - logic/ifm_buffer.sv
      - logic/conv_ctrl.sv
      - logic/window_shift.sv
      - logic/conv_mac.sv
      - logic/ofm_store.sv
      - logic/conv_layer_top.sv
      - target: test
        files:
          - dv/conv_layer_tb.sv

// File: build.f
+incdir+include
logic/conv_pkg.sv
logic/ifm_buffer.sv
logic/conv_ctrl.sv
logic/window_shift.sv
logic/conv_mac.sv
logic/ofm_store.sv
logic/conv_layer_top.sv
dv/conv_layer_tb.sv

// File: dv/conv_layer_tb.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module conv_layer_tb;

    localparam int IFM   = `CONV_IFM_SIZE;
    localparam int K     = `CONV_KERNEL_SIZE;
    localparam int DEPTH = `CONV_IFM_DEPTH;
    localparam int FILT  = `CONV_FILTERS;
    localparam int OFM   = `CONV_OFM_SIZE;
    localparam int IFM_N = DEPTH * IFM * IFM;
    localparam int WGT_N = FILT * DEPTH * K * K;
    localparam int OFM_N = FILT * OFM * OFM;
    localparam int RUN_TIMEOUT = 2000;

    logic                clk;
    logic                reset;
    logic                ifm_wr_en;
    conv_pkg::ifm_addr_t ifm_wr_addr;
    conv_pkg::pix_t      ifm_wr_data;
    logic                wgt_wr_en;
    conv_pkg::wgt_addr_t wgt_wr_addr;
    conv_pkg::wgt_t      wgt_wr_data;
    logic                start_from_previous;
    logic                end_to_previous;
    logic                end_from_next;
    logic                start_to_next;
    conv_pkg::ofm_addr_t ofm_rd_addr;
    conv_pkg::sum_t      ofm_rd_data;

    logic [31:0] lfsr;
    int ifm_m [IFM_N];
    int wgt_m [WGT_N];
    int exp_m [OFM_N];
    int exp_hold [OFM_N];   // first run kept while the second waits
    int value_errors;
    int proto_errors;

    conv_layer_top UUT (
        .clk                 (clk),
        .reset               (reset),
        .ifm_wr_en           (ifm_wr_en),
        .ifm_wr_addr         (ifm_wr_addr),
        .ifm_wr_data         (ifm_wr_data),
        .wgt_wr_en           (wgt_wr_en),
        .wgt_wr_addr         (wgt_wr_addr),
        .wgt_wr_data         (wgt_wr_data),
        .start_from_previous (start_from_previous),
        .end_to_previous     (end_to_previous),
        .end_from_next       (end_from_next),
        .start_to_next       (start_to_next),
        .ofm_rd_addr         (ofm_rd_addr),
        .ofm_rd_data         (ofm_rd_data)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic int ref_out(input int f, input int r, input int c);
        int acc;
        acc = 0;
        for (int ch = 0; ch < DEPTH; ch++)
            for (int kr = 0; kr < K; kr++)
                for (int kc = 0; kc < K; kc++)
                    acc += ifm_m[ch*IFM*IFM + (r + kr)*IFM + c + kc]
                         * wgt_m[((f*DEPTH + ch)*K + kr)*K + kc];
        return (acc < 0) ? 0 : acc;  // relu
    endfunction

    task automatic build_model();
        for (int f = 0; f < FILT; f++)
            for (int r = 0; r < OFM; r++)
                for (int c = 0; c < OFM; c++)
                    exp_m[f*OFM*OFM + r*OFM + c] = ref_out(f, r, c);
    endtask

    ////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////

    // negative weights and positive pixels in relu mode
    task automatic load_layer(input bit relu_mode);
        logic [31:0] v;
        @(negedge clk);
        if (!end_to_previous)
        begin
            proto_errors++;
            $display("Input buffer load attempted while end_to_previous was low");
        end
        for (int i = 0; i < WGT_N; i++)
        begin
            take_bits(8, v);
            wgt_m[i] = relu_mode ? -1 - int'(v[6:0]) : $signed(v[7:0]);
            @(posedge clk);
            #1;
            wgt_wr_en   = 1'b1;
            wgt_wr_addr = conv_pkg::wgt_addr_t'(i);
            wgt_wr_data = conv_pkg::wgt_t'(wgt_m[i]);
        end
        for (int i = 0; i < IFM_N; i++)
        begin
            take_bits(8, v);
            ifm_m[i] = relu_mode ? 1 + int'(v[5:0]) : $signed(v[7:0]);
            @(posedge clk);
            #1;
            wgt_wr_en   = 1'b0;
            ifm_wr_en   = 1'b1;
            ifm_wr_addr = conv_pkg::ifm_addr_t'(i);
            ifm_wr_data = conv_pkg::pix_t'(ifm_m[i]);
        end
        @(posedge clk);
        #1;
        ifm_wr_en = 1'b0;
    endtask

    task automatic start_layer();
        @(posedge clk);
        #1;
        start_from_previous = 1'b1;
        @(posedge clk);
        #1;
        start_from_previous = 1'b0;
    endtask

    task automatic read_ofm(input int addr, output int data);
        @(posedge clk);
        #1;
        ofm_rd_addr = conv_pkg::ofm_addr_t'(addr);
        @(posedge clk);
        @(negedge clk);
        data = ofm_rd_data;
    endtask

    task automatic check_outputs(input bit from_hold, input string what);
        int got;
        int want;
        for (int a = 0; a < OFM_N; a++)
        begin
            read_ofm(a, got);
            want = from_hold ? exp_hold[a] : exp_m[a];
            if (got != want)
            begin
                value_errors++;
                $display("Error at time %0t: %s ofm[%0d] = %0d, expected %0d",
                         $time, what, a, got, want);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // waits
    ////////////////////////////////////////////////////////////

    task automatic wait_result(output bit etp_low);
        int  n;
        bit  seen;
        n = 0;
        seen = 1'b0;
        etp_low = 1'b0;
        while (!seen && n < RUN_TIMEOUT)
        begin
            @(negedge clk);
            if (!end_to_previous)
                etp_low = 1'b1;
            if (start_to_next)
                seen = 1'b1;
            n++;
        end
        if (!seen)
        begin
            proto_errors++;
            $display("Timeout: no start_to_next within %0d cycles", RUN_TIMEOUT);
        end
    endtask

    task automatic wait_etp(input logic level, input int limit);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (end_to_previous !== level && n < limit);
        if (end_to_previous !== level)
        begin
            proto_errors++;
            $display("Timeout: end_to_previous did not reach %0b within %0d cycles",
                     level, limit);
        end
    endtask

    // counts start_to_next pulses over a window of cycles
    task automatic count_pulses(input int cycles, output int pulses);
        pulses = 0;
        for (int n = 0; n < cycles; n++)
        begin
            @(negedge clk);
            if (start_to_next)
                pulses++;
        end
    endtask

    task automatic run_and_check(input bit relu_mode, input string what);
        bit etp_low;
        load_layer(relu_mode);
        build_model();
        start_layer();
        wait_result(etp_low);
        if (!etp_low)
        begin
            proto_errors++;
            $display("end_to_previous never went low during the %s", what);
        end
        if (!end_to_previous)
        begin
            proto_errors++;
            $display("end_to_previous not high after the %s completed", what);
        end
        check_outputs(1'b0, what);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int  pulses;
        bit  etp_low;
        clk = 1'b0;
        reset = 1'b1;
        ifm_wr_en = 1'b0;
        ifm_wr_addr = '0;
        ifm_wr_data = '0;
        wgt_wr_en = 1'b0;
        wgt_wr_addr = '0;
        wgt_wr_data = '0;
        start_from_previous = 1'b0;
        end_from_next = 1'b0;
        ofm_rd_addr = '0;
        lfsr = 32'hbc76_3119;
        value_errors = 0;
        proto_errors = 0;

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (end_to_previous !== 1'b1 || start_to_next !== 1'b0)
        begin
            proto_errors++;
            $display("Handshake outputs wrong after reset");
        end

        @(posedge clk);
        #1;
        end_from_next = 1'b1;
        run_and_check(1'b0, "random run");
        run_and_check(1'b1, "relu run");

        // back-pressure with the next layer busy
        @(posedge clk);
        #1;
        end_from_next = 1'b0;
        load_layer(1'b0);
        build_model();
        for (int a = 0; a < OFM_N; a++)
            exp_hold[a] = exp_m[a];
        start_layer();
        wait_etp(1'b0, 10);
        wait_etp(1'b1, RUN_TIMEOUT);
        count_pulses(100, pulses);
        if (pulses != 0)
        begin
            proto_errors++;
            $display("start_to_next pulsed while end_from_next was low");
        end

        load_layer(1'b0);
        build_model();
        start_layer();
        count_pulses(20, pulses);
        if (pulses != 0)
        begin
            proto_errors++;
            $display("start_to_next pulsed during hold with end_from_next low");
        end
        check_outputs(1'b1, "held run");

        @(posedge clk);
        #1;
        end_from_next = 1'b1;
        count_pulses(20, pulses);
        if (pulses != 1)
        begin
            proto_errors++;
            $display("Expected one start_to_next pulse on release, saw %0d", pulses);
        end
        wait_result(etp_low);
        if (!etp_low)
        begin
            proto_errors++;
            $display("end_to_previous never went low during the queued run");
        end
        check_outputs(1'b0, "queued run");

        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: include/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

////////////////////////////////////////////////////////////
// layer geometry
////////////////////////////////////////////////////////////

`define CONV_IFM_SIZE       8
`define CONV_KERNEL_SIZE    3
`define CONV_IFM_DEPTH      2
`define CONV_FILTERS        2
`define CONV_OFM_SIZE       (`CONV_IFM_SIZE - `CONV_KERNEL_SIZE + 1)

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define CONV_PIX_W          8
`define CONV_SUM_W          22  // 16 bit products, 9 taps, 2 channels

// pixels held by the line buffer
`define CONV_FIFO_DEPTH     ((`CONV_KERNEL_SIZE - 1) * `CONV_IFM_SIZE + `CONV_KERNEL_SIZE)
`define CONV_MAC_LAT        2

// address widths
`define CONV_IFM_AW  $clog2(`CONV_IFM_DEPTH * `CONV_IFM_SIZE * `CONV_IFM_SIZE)
`define CONV_OFM_AW  $clog2(`CONV_FILTERS * `CONV_OFM_SIZE * `CONV_OFM_SIZE)
`define CONV_WGT_AW  $clog2(`CONV_FILTERS * `CONV_IFM_DEPTH * `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE)

`endif

// File: logic/conv_ctrl.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module conv_ctrl
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_from_previous,
    input  logic                end_from_next,
    output logic                end_to_previous,
    output logic                start_to_next,
    output logic                ifm_rd_en,
    output conv_pkg::ifm_addr_t ifm_rd_addr,
    output logic                shift_en,
    output logic                win_valid,
    output conv_pkg::wgt_addr_t wgt_base,
    output conv_pkg::ofm_wr_t   tag
);

    localparam int PLANE = `CONV_IFM_SIZE * `CONV_IFM_SIZE;
    localparam int OFM_PLANE = `CONV_OFM_SIZE * `CONV_OFM_SIZE;
    localparam int KK = `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE;
    localparam int CW = $clog2(`CONV_IFM_DEPTH + 1);
    localparam int FW = $clog2(`CONV_FILTERS + 1);
    localparam int DRAIN = `CONV_MAC_LAT + 2;   // buffer read, shift, mac

    conv_pkg::ctrl_state_e state, state_next;
    conv_pkg::win_state_e  win_state;

    logic [$clog2(PLANE)-1:0]            pix_cnt;
    logic [CW-1:0]                       chan_cnt, win_chan;
    logic [FW-1:0]                       filter_cnt, win_filter;
    logic [$clog2(`CONV_FIFO_DEPTH)-1:0] win_cnt;
    conv_pkg::ofm_addr_t                 ofm_pix;
    logic [DRAIN-1:0]                    drain_pipe;
    logic plane_end, last_plane, run_end;
    logic result_pending, out_busy;

    ////////////////////////////////////////////////////////////
    // main state machine
    ////////////////////////////////////////////////////////////

    assign plane_end  = (state == conv_pkg::READ) && (pix_cnt == PLANE - 1);
    assign last_plane = (chan_cnt == `CONV_IFM_DEPTH - 1) && (filter_cnt == `CONV_FILTERS - 1);
    assign run_end    = plane_end && last_plane;
    assign out_busy   = result_pending || (|drain_pipe);  // store still owned by last run

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= conv_pkg::IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            conv_pkg::IDLE:
                if (start_from_previous)
                    state_next = out_busy ? conv_pkg::HOLD : conv_pkg::READ;
            conv_pkg::HOLD:
                if (!out_busy)
                    state_next = conv_pkg::READ;
            conv_pkg::READ:
                if (plane_end)
                    state_next = last_plane ? conv_pkg::IDLE : conv_pkg::FINISH;
            conv_pkg::FINISH:
                state_next = conv_pkg::READ;  // one idle cycle flushes the window
            default:
                state_next = conv_pkg::IDLE;
        endcase
    end

    assign end_to_previous = (state == conv_pkg::IDLE);
    assign ifm_rd_en       = (state == conv_pkg::READ);
    assign ifm_rd_addr     = conv_pkg::ifm_addr_t'(chan_cnt * PLANE + pix_cnt);

    // channels inner and filters outer
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pix_cnt    <= '0;
            chan_cnt   <= '0;
            filter_cnt <= '0;
        end
        else if (plane_end)
        begin
            pix_cnt <= '0;
            if (chan_cnt == `CONV_IFM_DEPTH - 1)
            begin
                chan_cnt   <= '0;
                filter_cnt <= (filter_cnt == `CONV_FILTERS - 1) ? '0 : filter_cnt + 1'b1;
            end
            else
                chan_cnt <= chan_cnt + 1'b1;
        end
        else if (state == conv_pkg::READ)
            pix_cnt <= pix_cnt + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // window validity
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_en  <= 1'b0;
            win_state <= conv_pkg::FILL;
            win_cnt   <= '0;
        end
        else
        begin
            shift_en <= ifm_rd_en;  // aligned with buffer data
            if (!shift_en)
            begin
                win_state <= conv_pkg::FILL;
                win_cnt   <= '0;
            end
            else
            begin
                win_cnt <= win_cnt + 1'b1;
                case (win_state)
                    conv_pkg::FILL:
                        if (win_cnt == `CONV_FIFO_DEPTH - 1)
                        begin
                            win_state <= conv_pkg::READY;
                            win_cnt   <= '0;
                        end
                    conv_pkg::READY:
                        if (win_cnt == `CONV_OFM_SIZE - 1)
                        begin
                            win_state <= conv_pkg::SKIP;
                            win_cnt   <= '0;
                        end
                    conv_pkg::SKIP:
                        if (win_cnt == `CONV_KERNEL_SIZE - 2)  // row wrap columns
                        begin
                            win_state <= conv_pkg::READY;
                            win_cnt   <= '0;
                        end
                    default:
                        win_state <= conv_pkg::FILL;
                endcase
            end
        end
    end

    assign win_valid = (win_state == conv_pkg::READY);

    // plane identity of the windows in flight taken on the first shift
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            win_chan   <= '0;
            win_filter <= '0;
            ofm_pix    <= '0;
        end
        else
        begin
            if (win_state == conv_pkg::FILL && shift_en && win_cnt == '0)
            begin
                win_chan   <= chan_cnt;
                win_filter <= filter_cnt;
            end
            if (win_state == conv_pkg::FILL)
                ofm_pix <= '0;
            else if (win_valid)
                ofm_pix <= ofm_pix + 1'b1;
        end
    end

    assign wgt_base  = conv_pkg::wgt_addr_t'((win_filter * `CONV_IFM_DEPTH + win_chan) * KK);
    assign tag.addr  = conv_pkg::ofm_addr_t'(win_filter * OFM_PLANE) + ofm_pix;
    assign tag.first = (win_chan == 0);
    assign tag.last  = (win_chan == `CONV_IFM_DEPTH - 1);

    ////////////////////////////////////////////////////////////
    // next layer handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            drain_pipe     <= '0;
            result_pending <= 1'b0;
        end
        else
        begin
            drain_pipe <= {drain_pipe[DRAIN-2:0], run_end};
            if (drain_pipe[DRAIN-1])       // final relu write lands now
                result_pending <= 1'b1;
            else if (start_to_next)
                result_pending <= 1'b0;
        end
    end

    assign start_to_next = result_pending && end_from_next;

    // a run always begins at pixel 0 of channel 0 and filter 0
    a_idle_at_origin: assert property (@(posedge clk) disable iff (reset)
        state == conv_pkg::IDLE |-> ifm_rd_addr == '0 && filter_cnt == '0);

    // single cycle pulse once the pipeline has drained
    a_start_next: assert property (@(posedge clk) disable iff (reset)
        start_to_next |-> drain_pipe == '0 ##1 !start_to_next);

endmodule

// File: logic/conv_layer_top.sv
`timescale 1ns/1ps

module conv_layer_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ifm_wr_en,
    input  conv_pkg::ifm_addr_t ifm_wr_addr,
    input  conv_pkg::pix_t      ifm_wr_data,
    input  logic                wgt_wr_en,
    input  conv_pkg::wgt_addr_t wgt_wr_addr,
    input  conv_pkg::wgt_t      wgt_wr_data,
    input  logic                start_from_previous,
    output logic                end_to_previous,
    input  logic                end_from_next,
    output logic                start_to_next,
    input  conv_pkg::ofm_addr_t ofm_rd_addr,
    output conv_pkg::sum_t      ofm_rd_data
);

    logic                ifm_rd_en, shift_en, win_valid, sum_valid;
    conv_pkg::ifm_addr_t ifm_rd_addr;
    conv_pkg::pix_t      ifm_rd_data;
    conv_pkg::window_t   window;
    conv_pkg::wgt_addr_t wgt_base;
    conv_pkg::ofm_wr_t   win_tag, sum_tag;
    conv_pkg::sum_t      sum;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    ifm_buffer u_ifm_buffer (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (ifm_wr_en),
        .wr_addr (ifm_wr_addr),
        .wr_data (ifm_wr_data),
        .rd_en   (ifm_rd_en),
        .rd_addr (ifm_rd_addr),
        .rd_data (ifm_rd_data)
    );

    conv_ctrl u_conv_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .start_from_previous (start_from_previous),
        .end_from_next       (end_from_next),
        .end_to_previous     (end_to_previous),
        .start_to_next       (start_to_next),
        .ifm_rd_en           (ifm_rd_en),
        .ifm_rd_addr         (ifm_rd_addr),
        .shift_en            (shift_en),
        .win_valid           (win_valid),
        .wgt_base            (wgt_base),
        .tag                 (win_tag)
    );

    ////////////////////////////////////////////////////////////
    // processing and output side
    ////////////////////////////////////////////////////////////

    window_shift u_window_shift (
        .clk      (clk),
        .reset    (reset),
        .shift_en (shift_en),
        .din      (ifm_rd_data),
        .window   (window)
    );

    conv_mac u_conv_mac (
        .clk         (clk),
        .reset       (reset),
        .wgt_wr_en   (wgt_wr_en),
        .wgt_wr_addr (wgt_wr_addr),
        .wgt_wr_data (wgt_wr_data),
        .win_valid   (win_valid),
        .window      (window),
        .wgt_base    (wgt_base),
        .tag_in      (win_tag),
        .sum_valid   (sum_valid),
        .sum         (sum),
        .tag_out     (sum_tag)
    );

    ofm_store u_ofm_store (
        .clk       (clk),
        .reset     (reset),
        .sum_valid (sum_valid),
        .sum       (sum),
        .tag       (sum_tag),
        .rd_addr   (ofm_rd_addr),
        .rd_data   (ofm_rd_data)
    );

endmodule

// File: logic/conv_mac.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module conv_mac
(
    input  logic                clk,
    input  logic                reset,
    input  logic                wgt_wr_en,
    input  conv_pkg::wgt_addr_t wgt_wr_addr,
    input  conv_pkg::wgt_t      wgt_wr_data,
    input  logic                win_valid,
    input  conv_pkg::window_t   window,
    input  conv_pkg::wgt_addr_t wgt_base,
    input  conv_pkg::ofm_wr_t   tag_in,
    output logic                sum_valid,
    output conv_pkg::sum_t      sum,
    output conv_pkg::ofm_wr_t   tag_out
);

    localparam int KK = `CONV_KERNEL_SIZE * `CONV_KERNEL_SIZE;
    localparam int WENTRIES = `CONV_FILTERS * `CONV_IFM_DEPTH * KK;

    conv_pkg::wgt_t      wmem [WENTRIES];
    conv_pkg::wgt_t      wreg [KK];
    conv_pkg::wgt_addr_t cur_base;
    logic                reload_pend, reload;

    logic signed [2*`CONV_PIX_W-1:0] prod [KK];
    logic                            v1;
    conv_pkg::ofm_wr_t               tag1;
    conv_pkg::sum_t                  tree;

    always_ff @(posedge clk)
    begin
        if (wgt_wr_en)
            wmem[wgt_wr_addr] <= wgt_wr_data;
    end

    ////////////////////////////////////////////////////////////
    // active kernel registers
    ////////////////////////////////////////////////////////////

    assign reload = reload_pend || (wgt_base != cur_base);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            cur_base    <= '0;
            reload_pend <= 1'b1;
        end
        else
        begin
            if (reload)
            begin
                cur_base    <= wgt_base;
                reload_pend <= 1'b0;
            end
            if (wgt_wr_en)
                reload_pend <= 1'b1;  // memory changed under the copy
        end
    end

    always_ff @(posedge clk)
    begin
        if (reload)
        begin
            for (int i = 0; i < KK; i++)
                wreg[i] <= wmem[wgt_base + conv_pkg::wgt_addr_t'(i)];
        end
    end

    // stage 1 multiplies, stage 2 adds
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < KK; i++)
            prod[i] <= window.pix[i] * wreg[i];
        tag1    <= tag_in;
        sum     <= tree;
        tag_out <= tag1;
    end

    always_comb
    begin
        tree = '0;
        for (int i = 0; i < KK; i++)
            tree = tree + prod[i];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            v1        <= 1'b0;
            sum_valid <= 1'b0;
        end
        else
        begin
            v1        <= win_valid;
            sum_valid <= v1;
        end
    end

endmodule

// File: logic/conv_pkg.sv
`include "conv_defs.svh"

package conv_pkg;

    typedef logic signed [`CONV_PIX_W-1:0] pix_t;
    typedef logic signed [`CONV_PIX_W-1:0] wgt_t;
    typedef logic signed [`CONV_SUM_W-1:0] sum_t;

    typedef logic [`CONV_IFM_AW-1:0] ifm_addr_t;    // channel major
    typedef logic [`CONV_OFM_AW-1:0] ofm_addr_t;    // filter major
    typedef logic [`CONV_WGT_AW-1:0] wgt_addr_t;    // filter, channel, row, column

    // K*K window, element r*K+c
    typedef struct packed {
        pix_t [`CONV_KERNEL_SIZE*`CONV_KERNEL_SIZE-1:0] pix;
    } window_t;

    // output write tag, travels beside the window
    typedef struct packed {
        ofm_addr_t addr;
        logic      first;  // first channel, overwrite
        logic      last;   // last channel, relu
    } ofm_wr_t;

    typedef enum logic [1:0] {IDLE, READ, FINISH, HOLD} ctrl_state_e;

    typedef enum logic [1:0] {FILL, READY, SKIP} win_state_e;

endpackage

// File: logic/ifm_buffer.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module ifm_buffer
(
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_en,
    input  conv_pkg::ifm_addr_t wr_addr,
    input  conv_pkg::pix_t      wr_data,
    input  logic                rd_en,
    input  conv_pkg::ifm_addr_t rd_addr,
    output conv_pkg::pix_t      rd_data
);

    localparam int ENTRIES = `CONV_IFM_DEPTH * `CONV_IFM_SIZE * `CONV_IFM_SIZE;

    conv_pkg::pix_t mem [ENTRIES];

    // written by the previous layer while end_to_previous is high
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rd_data <= '0;
        else if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/ofm_store.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module ofm_store
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sum_valid,
    input  conv_pkg::sum_t      sum,
    input  conv_pkg::ofm_wr_t   tag,
    input  conv_pkg::ofm_addr_t rd_addr,
    output conv_pkg::sum_t      rd_data
);

    localparam int ENTRIES = `CONV_FILTERS * `CONV_OFM_SIZE * `CONV_OFM_SIZE;

    conv_pkg::sum_t mem [ENTRIES];
    conv_pkg::sum_t acc;

    // partial sum across channels, relu on the last one
    always_comb
    begin
        acc = tag.first ? sum : mem[tag.addr] + sum;
        if (tag.last && acc < 0)
            acc = '0;
    end

    always_ff @(posedge clk)
    begin
        if (sum_valid)
            mem[tag.addr] <= acc;
    end

    // next layer read port
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rd_data <= '0;
        else
            rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/window_shift.sv
`timescale 1ns/1ps

`include "conv_defs.svh"

module window_shift
(
    input  logic              clk,
    input  logic              reset,
    input  logic              shift_en,
    input  conv_pkg::pix_t    din,
    output conv_pkg::window_t window
);

    localparam int N = `CONV_FIFO_DEPTH;
    localparam int K = `CONV_KERNEL_SIZE;

    // sr[0] newest, sr[j] is the pixel j places back in raster order
    conv_pkg::pix_t sr [N];

    always_ff @(posedge clk)
    begin
        if (shift_en)
        begin
            sr[0] <= din;
            for (int i = 1; i < N; i++)
                sr[i] <= sr[i-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // taps, one row stride apart
    ////////////////////////////////////////////////////////////

    // newest pixel is the bottom right corner
    always_comb
    begin
        for (int r = 0; r < K; r++)
        begin
            for (int c = 0; c < K; c++)
                window.pix[r*K + c] = sr[(K - 1 - r) * `CONV_IFM_SIZE + (K - 1 - c)];
        end
    end

    // buffer data must be settled by the time it is shifted in
    a_din_known: assert property (@(posedge clk) disable iff (reset)
        shift_en |-> !$isunknown(din));

endmodule
